//--- design/xif_macros.svh
// sizes shared by the coprocessor subsystem, included by every RTL file that needs them.
`ifndef XIF_MACROS_SVH
`define XIF_MACROS_SVH

// number of coprocessors behind the issue port.
`define XIF_N_COPROC 3

// rule slots per coprocessor.
`define XIF_N_OPCODE 2

// coprocessor that gets unmatched opcodes.
// it accepts nothing, so the core sees a reject.
`define XIF_DEFAULT_IDX 2

// major opcode field width.
`define XIF_OPCODE_W 7

// operand, result and apb data width.
`define XIF_DATA_W 32

// instruction id width.
`define XIF_ID_W 4

// apb address width, byte addressed.
`define XIF_APB_AW 8

`endif

//--- design/xif_pkg.sv
// instruction word types for the coprocessor subsystem, imported by modules that decode it.
`include "xif_macros.svh"

package xif_pkg;

  // r-type view of a 32-bit instruction.
  // msb first, so opcode sits in bits 6:0.
  typedef struct packed {
    logic [6:0]               funct7;
    logic [4:0]               rs2;
    logic [4:0]               rs1;
    // operation select inside the coprocessor.
    logic [2:0]               funct3;
    // destination register, echoed on the result.
    logic [4:0]               rd;
    // routing key for the demux.
    logic [`XIF_OPCODE_W-1:0] opcode;
  } xif_rtype_t;

  // one instruction word, read two ways.
  // raw for whole-word drive and compare.
  // f for the decoded fields.
  typedef union packed {
    logic [31:0] raw;
    xif_rtype_t  f;
  } xif_instr_u;

endpackage : xif_pkg

//--- design/xif_rule_regs.sv
// apb register file holding the opcode routing rules, one slot per coprocessor opcode.
`include "xif_macros.svh"

module xif_rule_regs (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  // apb slave.
  input  logic                                        psel_i,
  input  logic                                        penable_i,
  input  logic                                        pwrite_i,
  input  logic [`XIF_APB_AW-1:0]                      paddr_i,
  input  logic [`XIF_DATA_W-1:0]                      pwdata_i,
  output logic [`XIF_DATA_W-1:0]                      prdata_o,
  output logic                                        pready_o,
  output logic                                        pslverr_o,
  // rules, slot c*N_OPCODE+s is slot s of coprocessor c.
  output logic [`XIF_N_COPROC*`XIF_N_OPCODE*`XIF_OPCODE_W-1:0] rule_opcode_o,
  output logic [`XIF_N_COPROC*`XIF_N_OPCODE-1:0]              rule_en_o
);

  localparam int N_SLOT   = `XIF_N_COPROC * `XIF_N_OPCODE;
  localparam int OPCODE_W = `XIF_OPCODE_W;
  localparam int DATA_W   = `XIF_DATA_W;
  localparam int IDX_W    = `XIF_APB_AW - 2;

  logic [IDX_W-1:0]    word_idx;
  logic                in_range;
  logic                wr_en;
  logic [OPCODE_W-1:0] opcode_q [N_SLOT];
  logic [N_SLOT-1:0]   en_q;

  // word aligned, low two address bits ignored.
  assign word_idx = paddr_i[`XIF_APB_AW-1:2];
  assign in_range = (word_idx < IDX_W'(N_SLOT));

  // no wait states.
  assign pready_o = 1'b1;

  // error only in the access phase.
  assign pslverr_o = psel_i & penable_i & ~in_range;

  // out of range writes are dropped.
  assign wr_en = psel_i & penable_i & pwrite_i & in_range;

  // rule storage.
  // all slots disabled after reset.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < N_SLOT; s++) begin
        opcode_q[s] <= '0;
      end
      en_q <= '0;
    end else if (wr_en) begin
      for (int s = 0; s < N_SLOT; s++) begin
        if (word_idx == IDX_W'(s)) begin
          opcode_q[s] <= pwdata_i[OPCODE_W-1:0];
          // enable sits just above the opcode.
          en_q[s]     <= pwdata_i[OPCODE_W];
        end
      end
    end
  end

  // read mux, zero when nothing decodes.
  always_comb begin
    prdata_o = '0;
    for (int s = 0; s < N_SLOT; s++) begin
      if (word_idx == IDX_W'(s)) begin
        prdata_o = {{(DATA_W-OPCODE_W-1){1'b0}}, en_q[s], opcode_q[s]};
      end
    end
  end

  // flatten for the demux.
  for (genvar s = 0; s < N_SLOT; s++) begin : gen_rule_out
    assign rule_opcode_o[s*OPCODE_W +: OPCODE_W] = opcode_q[s];
  end
  assign rule_en_o = en_q;

  // setup phase must precede every access phase.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) penable_i |-> psel_i)
    else $error("apb penable high without psel");

endmodule : xif_rule_regs

//--- design/xif_issue_demux.sv
// routes each issued instruction to one coprocessor by opcode and returns its response.
`include "xif_macros.svh"

module xif_issue_demux
  import xif_pkg::*;
(
  // rules from the register file.
  input  logic [`XIF_N_COPROC*`XIF_N_OPCODE*`XIF_OPCODE_W-1:0] rule_opcode_i,
  input  logic [`XIF_N_COPROC*`XIF_N_OPCODE-1:0]              rule_en_i,
  // core side issue.
  input  logic                     issue_valid_i,
  input  xif_instr_u               issue_instr_i,
  input  logic [`XIF_DATA_W-1:0]   issue_rs1_i,
  input  logic [`XIF_DATA_W-1:0]   issue_rs2_i,
  input  logic [`XIF_ID_W-1:0]     issue_id_i,
  output logic                     issue_ready_o,
  output logic                     issue_accept_o,
  output logic                     issue_writeback_o,
  // coprocessor side issue.
  output logic [`XIF_N_COPROC-1:0] cp_valid_o,
  output xif_instr_u               cp_instr_o,
  output logic [`XIF_DATA_W-1:0]   cp_rs1_o,
  output logic [`XIF_DATA_W-1:0]   cp_rs2_o,
  output logic [`XIF_ID_W-1:0]     cp_id_o,
  input  logic [`XIF_N_COPROC-1:0] cp_ready_i,
  input  logic [`XIF_N_COPROC-1:0] cp_accept_i,
  input  logic [`XIF_N_COPROC-1:0] cp_writeback_i
);

  localparam int N_COPROC    = `XIF_N_COPROC;
  localparam int N_OPCODE    = `XIF_N_OPCODE;
  localparam int OPCODE_W    = `XIF_OPCODE_W;
  localparam int DEFAULT_IDX = `XIF_DEFAULT_IDX;

  logic [OPCODE_W-1:0] opcode;
  // coprocessors whose enabled rules hit the opcode.
  logic [N_COPROC-1:0] match;
  // match with the default fallback applied.
  logic [N_COPROC-1:0] route;
  // lowest set bit of route.
  logic [N_COPROC-1:0] sel;

  assign opcode = issue_instr_i.f.opcode;

  // opcode matcher.
  // a disabled slot never hits.
  always_comb begin
    match = '0;
    for (int c = 0; c < N_COPROC; c++) begin
      for (int s = 0; s < N_OPCODE; s++) begin
        if (rule_en_i[c*N_OPCODE+s] &&
            rule_opcode_i[(c*N_OPCODE+s)*OPCODE_W +: OPCODE_W] == opcode) begin
          match[c] = 1'b1;
        end
      end
    end
  end

  // nothing hit, send to the default coprocessor.
  always_comb begin
    route = match;
    if (match == '0) begin
      route[DEFAULT_IDX] = 1'b1;
    end
  end

  // lowest index wins on duplicate rules.
  assign sel = route & (~route + N_COPROC'(1));

  // valid only to the selected one.
  // data goes out to all, valid qualifies it.
  assign cp_valid_o = sel & {N_COPROC{issue_valid_i}};
  assign cp_instr_o = issue_instr_i;
  assign cp_rs1_o   = issue_rs1_i;
  assign cp_rs2_o   = issue_rs2_i;
  assign cp_id_o    = issue_id_i;

  // response from the selected coprocessor, same cycle.
  always_comb begin
    issue_ready_o     = 1'b0;
    issue_accept_o    = 1'b0;
    issue_writeback_o = 1'b0;
    for (int c = 0; c < N_COPROC; c++) begin
      if (sel[c]) begin
        issue_ready_o     = cp_ready_i[c];
        issue_accept_o    = cp_accept_i[c];
        issue_writeback_o = cp_writeback_i[c];
      end
    end
  end

  // never offer one instruction to two coprocessors.
  always_comb begin
    assert ($onehot0(cp_valid_o))
      else $error("issue valid steered to more than one coprocessor");
  end

endmodule : xif_issue_demux

//--- design/xif_coproc.sv
// single-cycle alu coprocessor that accepts a funct3 subset and returns results one per issue.
`include "xif_macros.svh"

module xif_coproc
  import xif_pkg::*;
#(
  // bit n set means funct3 n is supported.
  parameter logic [7:0] ACCEPT_MASK = 8'hFF
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  // issue.
  input  logic                   issue_valid_i,
  input  xif_instr_u             issue_instr_i,
  input  logic [`XIF_DATA_W-1:0] issue_rs1_i,
  input  logic [`XIF_DATA_W-1:0] issue_rs2_i,
  input  logic [`XIF_ID_W-1:0]   issue_id_i,
  output logic                   issue_ready_o,
  output logic                   issue_accept_o,
  output logic                   issue_writeback_o,
  // result.
  input  logic                   result_ready_i,
  output logic                   result_valid_o,
  output logic [`XIF_DATA_W-1:0] result_data_o,
  output logic [`XIF_ID_W-1:0]   result_id_o,
  output logic [4:0]             result_rd_o
);

  logic [2:0]             funct3;
  logic                   load;
  logic [`XIF_DATA_W-1:0] alu_res;

  assign funct3 = issue_instr_i.f.funct3;

  // free slot now, or the held result leaves this cycle.
  assign issue_ready_o = ~result_valid_o | result_ready_i;

  // accept decided by funct3 alone.
  assign issue_accept_o    = ACCEPT_MASK[funct3];
  assign issue_writeback_o = issue_accept_o;

  // rejected handshakes complete without a result.
  assign load = issue_valid_i & issue_ready_o & issue_accept_o;

  // alu.
  always_comb begin
    case (funct3)
      3'd0: alu_res = issue_rs1_i + issue_rs2_i;
      3'd1: alu_res = issue_rs1_i - issue_rs2_i;
      3'd2: alu_res = issue_rs1_i ^ issue_rs2_i;
      3'd3: alu_res = issue_rs1_i & issue_rs2_i;
      3'd4: alu_res = issue_rs1_i | issue_rs2_i;
      3'd5: alu_res = issue_rs1_i << issue_rs2_i[4:0];
      3'd6: alu_res = issue_rs1_i >> issue_rs2_i[4:0];
      // unsigned minimum.
      default: alu_res = (issue_rs1_i < issue_rs2_i) ? issue_rs1_i : issue_rs2_i;
    endcase
  end

  // output register valid.
  // a new load wins over a drain in the same cycle.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
    end else if (load) begin
      result_valid_o <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_o <= 1'b0;
    end
  end

  // output register payload.
  always_ff @(posedge clk_i) begin
    if (load) begin
      result_data_o <= alu_res;
      result_id_o   <= issue_id_i;
      result_rd_o   <= issue_instr_i.f.rd;
    end
  end

  // held result must not change under back-pressure.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   result_valid_o && !result_ready_i
                   |=> result_valid_o && $stable(result_data_o))
    else $error("coprocessor result changed while stalled");

endmodule : xif_coproc

//--- design/xif_result_arb.sv
// fixed-priority merge of the coprocessor result channels onto the single core result port.
`include "xif_macros.svh"

module xif_result_arb (
  // coprocessor side, flattened per coprocessor.
  input  logic [`XIF_N_COPROC-1:0]            cp_result_valid_i,
  input  logic [`XIF_N_COPROC*`XIF_DATA_W-1:0] cp_result_data_i,
  input  logic [`XIF_N_COPROC*`XIF_ID_W-1:0]   cp_result_id_i,
  input  logic [`XIF_N_COPROC*5-1:0]          cp_result_rd_i,
  output logic [`XIF_N_COPROC-1:0]            cp_result_ready_o,
  // core side.
  input  logic                                result_ready_i,
  output logic                                result_valid_o,
  output logic [`XIF_DATA_W-1:0]              result_data_o,
  output logic [`XIF_ID_W-1:0]                result_id_o,
  output logic [4:0]                          result_rd_o
);

  localparam int N_COPROC = `XIF_N_COPROC;
  localparam int DATA_W   = `XIF_DATA_W;
  localparam int ID_W     = `XIF_ID_W;

  // lowest pending index.
  logic [N_COPROC-1:0] gnt;

  assign gnt = cp_result_valid_i & (~cp_result_valid_i + N_COPROC'(1));

  assign result_valid_o = |cp_result_valid_i;

  // ready back to the granted one only.
  assign cp_result_ready_o = gnt & {N_COPROC{result_ready_i}};

  // payload mux on the grant.
  always_comb begin
    result_data_o = '0;
    result_id_o   = '0;
    result_rd_o   = '0;
    for (int c = 0; c < N_COPROC; c++) begin
      if (gnt[c]) begin
        result_data_o = cp_result_data_i[c*DATA_W +: DATA_W];
        result_id_o   = cp_result_id_i[c*ID_W +: ID_W];
        result_rd_o   = cp_result_rd_i[c*5 +: 5];
      end
    end
  end

  // a result leaves from one coprocessor per transfer.
  always_comb begin
    assert ($onehot0(cp_result_ready_o))
      else $error("result ready granted to more than one coprocessor");
  end

endmodule : xif_result_arb

//--- design/xif_subsys_top.sv
// coprocessor subsystem top, wiring rule registers, issue demux, three coprocessors and arbiter.
`include "xif_macros.svh"

module xif_subsys_top
  import xif_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // apb rule programming.
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [`XIF_APB_AW-1:0]    paddr_i,
  input  logic [`XIF_DATA_W-1:0]    pwdata_i,
  output logic [`XIF_DATA_W-1:0]    prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // issue from the core.
  input  logic                      issue_valid_i,
  input  xif_instr_u                issue_instr_i,
  input  logic [`XIF_DATA_W-1:0]    issue_rs1_i,
  input  logic [`XIF_DATA_W-1:0]    issue_rs2_i,
  input  logic [`XIF_ID_W-1:0]      issue_id_i,
  output logic                      issue_ready_o,
  output logic                      issue_accept_o,
  output logic                      issue_writeback_o,
  // result to the core.
  input  logic                      result_ready_i,
  output logic                      result_valid_o,
  output logic [`XIF_DATA_W-1:0]    result_data_o,
  output logic [`XIF_ID_W-1:0]      result_id_o,
  output logic [4:0]                result_rd_o
);

  localparam int N_COPROC = `XIF_N_COPROC;
  localparam int DATA_W   = `XIF_DATA_W;
  localparam int ID_W     = `XIF_ID_W;
  // funct3 masks, coprocessor 0 in the low byte.
  // the default coprocessor takes nothing.
  localparam logic [N_COPROC*8-1:0] MASKS = {8'h00, 8'hF0, 8'h0F};

  logic [N_COPROC*`XIF_N_OPCODE*`XIF_OPCODE_W-1:0] rule_opcode;
  logic [N_COPROC*`XIF_N_OPCODE-1:0]               rule_en;

  // demux to coprocessors.
  logic [N_COPROC-1:0] cp_valid, cp_ready, cp_accept, cp_writeback;
  xif_instr_u          cp_instr;
  logic [DATA_W-1:0]   cp_rs1, cp_rs2;
  logic [ID_W-1:0]     cp_id;

  // coprocessors to arbiter.
  logic [N_COPROC-1:0]        res_valid, res_ready;
  logic [N_COPROC*DATA_W-1:0] res_data;
  logic [N_COPROC*ID_W-1:0]   res_id;
  logic [N_COPROC*5-1:0]      res_rd;

  xif_rule_regs u_rule_regs (
    .clk_i, .arst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .rule_opcode_o (rule_opcode),
    .rule_en_o     (rule_en)
  );

  xif_issue_demux u_issue_demux (
    .rule_opcode_i (rule_opcode), .rule_en_i (rule_en),
    .issue_valid_i, .issue_instr_i, .issue_rs1_i, .issue_rs2_i, .issue_id_i,
    .issue_ready_o, .issue_accept_o, .issue_writeback_o,
    .cp_valid_o (cp_valid), .cp_instr_o (cp_instr), .cp_rs1_o (cp_rs1),
    .cp_rs2_o (cp_rs2), .cp_id_o (cp_id), .cp_ready_i (cp_ready),
    .cp_accept_i (cp_accept), .cp_writeback_i (cp_writeback)
  );

  for (genvar c = 0; c < N_COPROC; c++) begin : gen_coproc
    xif_coproc #(.ACCEPT_MASK (MASKS[c*8 +: 8])) u_coproc (
      .clk_i, .arst_n_i,
      .issue_valid_i (cp_valid[c]), .issue_instr_i (cp_instr),
      .issue_rs1_i (cp_rs1), .issue_rs2_i (cp_rs2), .issue_id_i (cp_id),
      .issue_ready_o (cp_ready[c]), .issue_accept_o (cp_accept[c]),
      .issue_writeback_o (cp_writeback[c]),
      .result_ready_i (res_ready[c]), .result_valid_o (res_valid[c]),
      .result_data_o (res_data[c*DATA_W +: DATA_W]),
      .result_id_o (res_id[c*ID_W +: ID_W]), .result_rd_o (res_rd[c*5 +: 5])
    );
  end

  xif_result_arb u_result_arb (
    .cp_result_valid_i (res_valid), .cp_result_data_i (res_data),
    .cp_result_id_i (res_id), .cp_result_rd_i (res_rd),
    .cp_result_ready_o (res_ready),
    .result_ready_i, .result_valid_o, .result_data_o, .result_id_o, .result_rd_o
  );

endmodule : xif_subsys_top

//--- sim/xif_subsys_tb.sv
// self-checking testbench for the coprocessor subsystem, run as the simulation top.
`include "xif_macros.svh"

module xif_subsys_tb
  import xif_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SEED         = 83935;
  localparam int DATA_W       = `XIF_DATA_W;
  localparam int ID_W         = `XIF_ID_W;
  localparam int APB_AW       = `XIF_APB_AW;
  localparam int N_TEST       = 13;
  // entries covered by the routing loop before the priority check.
  localparam int N_ROUTE      = 11;
  localparam int RESET_CYCLES = 10;
  localparam int APB_ACCESSES = 20;
  // one extra entry of budget for the back-pressure sequence.
  localparam int CYCLE_LIMIT  = 40 * (N_TEST + 1) + 4 * APB_ACCESSES + RESET_CYCLES;
  // rule byte per slot with the enable in bit 7.
  localparam logic [7:0] RULE_VAL [6] = '{8'h8B, 8'h5B, 8'hAB, 8'h5B, 8'h33, 8'h13};

  logic              clk, arst_n;
  logic              psel, penable, pwrite, pready, pslverr;
  logic [APB_AW-1:0] paddr;
  logic [DATA_W-1:0] pwdata, prdata;
  logic              issue_valid, issue_ready, issue_accept, issue_writeback;
  xif_instr_u        issue_instr;
  logic [DATA_W-1:0] issue_rs1, issue_rs2, result_data;
  logic [ID_W-1:0]   issue_id, result_id;
  logic              result_ready, result_valid;
  logic [4:0]        result_rd;
  int                cycles;
  int                n_loaded;

  // stimulus table.
  string      tname    [N_TEST];
  xif_instr_u tinstr   [N_TEST];
  logic       texp_acc [N_TEST];
  logic       texp_res [N_TEST];
  int         thold    [N_TEST];

  xif_subsys_top dut_i (
    .clk_i (clk), .arst_n_i (arst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .issue_valid_i (issue_valid), .issue_instr_i (issue_instr), .issue_rs1_i (issue_rs1),
    .issue_rs2_i (issue_rs2), .issue_id_i (issue_id), .issue_ready_o (issue_ready),
    .issue_accept_o (issue_accept), .issue_writeback_o (issue_writeback),
    .result_ready_i (result_ready), .result_valid_o (result_valid),
    .result_data_o (result_data), .result_id_o (result_id), .result_rd_o (result_rd)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hang guard.
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    report_failure("simulation hung, cycle limit reached before the tests finished");
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) report_failure($sformatf("Error: %s expected %0b actual %0b", name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_id(input string name, input logic [ID_W-1:0] exp,
                          input logic [ID_W-1:0] act);
    if (act !== exp) report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_instr(input string name, input xif_instr_u exp, input xif_instr_u act);
    if (act.raw !== exp.raw) begin
      report_failure($sformatf("Error: %s expected %h actual %h", name, exp.raw, act.raw));
    end
  endtask

  // reference alu built from the funct3 operation list.
  function automatic logic [DATA_W-1:0] expect_alu(input logic [2:0] f3,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    case (f3)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a ^ b;
      3'd3: return a & b;
      3'd4: return a | b;
      3'd5: return a << b[4:0];
      3'd6: return a >> b[4:0];
      default: return (a < b) ? a : b;
    endcase
  endfunction

  function automatic xif_instr_u make_instr(input logic [6:0] op, input logic [2:0] f3,
                                            input logic [4:0] rd);
    xif_instr_u w;
    w.f.funct7 = 7'h00;
    w.f.rs2    = 5'd2;
    w.f.rs1    = 5'd1;
    w.f.funct3 = f3;
    w.f.rd     = rd;
    w.f.opcode = op;
    return w;
  endfunction

  task automatic add_entry(input string name, input logic [6:0] op, input logic [2:0] f3,
                           input logic acc, input logic res, input int hold);
    tname[n_loaded]    = name;
    // rd follows the entry index, so each result is traceable.
    tinstr[n_loaded]   = make_instr(op, f3, 5'(n_loaded + 3));
    texp_acc[n_loaded] = acc;
    texp_res[n_loaded] = res;
    thold[n_loaded]    = hold;
    n_loaded++;
  endtask

  task automatic build_table();
    n_loaded = 0;
    add_entry("cp0_add", 7'h0B, 3'd0, 1'b1, 1'b1, 0);
    add_entry("cp0_sub", 7'h0B, 3'd1, 1'b1, 1'b1, 2);
    add_entry("cp0_xor", 7'h0B, 3'd2, 1'b1, 1'b1, 0);
    add_entry("cp0_and", 7'h0B, 3'd3, 1'b1, 1'b1, 1);
    add_entry("cp0_or_reject", 7'h0B, 3'd4, 1'b0, 1'b0, 0);
    add_entry("cp1_or", 7'h2B, 3'd4, 1'b1, 1'b1, 0);
    add_entry("cp1_sll", 7'h2B, 3'd5, 1'b1, 1'b1, 3);
    add_entry("cp1_srl", 7'h2B, 3'd6, 1'b1, 1'b1, 0);
    add_entry("cp1_minu", 7'h2B, 3'd7, 1'b1, 1'b1, 1);
    add_entry("cp1_add_reject", 7'h2B, 3'd0, 1'b0, 1'b0, 0);
    add_entry("default_route", 7'h7B, 3'd0, 1'b0, 1'b0, 0);
    // duplicate rule where the lowest index owns the instruction.
    add_entry("prio_lowest", 7'h5B, 3'd5, 1'b0, 1'b0, 0);
    add_entry("prio_cp1", 7'h5B, 3'd5, 1'b1, 1'b1, 0);
  endtask

  // one apb transfer with a setup and an access phase.
  task automatic apb_access(input logic wr, input int idx, input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = APB_AW'(idx * 4);
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    // no wait states, every access completes in its first access cycle.
    check_bit("apb_pready", 1'b1, pready);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input int idx, input logic [DATA_W-1:0] wdata, output logic err);
    logic [DATA_W-1:0] ignored;
    apb_access(1'b1, idx, wdata, ignored, err);
  endtask

  task automatic apb_read(input int idx, output logic [DATA_W-1:0] rdata, output logic err);
    apb_access(1'b0, idx, '0, rdata, err);
  endtask

  // hold valid until ready, then take the response.
  task automatic do_issue(input xif_instr_u instr, input logic [DATA_W-1:0] rs1,
                          input logic [DATA_W-1:0] rs2, input logic [ID_W-1:0] id,
                          output logic acc, output logic wb);
    @(negedge clk);
    issue_valid = 1'b1;
    issue_instr = instr;
    issue_rs1   = rs1;
    issue_rs2   = rs2;
    issue_id    = id;
    @(posedge clk);
    while (!issue_ready) @(posedge clk);
    acc = issue_accept;
    wb  = issue_writeback;
    check_instr("issue_forward", instr, dut_i.cp_instr);
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  task automatic get_result(input string name, input logic [DATA_W-1:0] exp_data,
                            input logic [ID_W-1:0] exp_id, input logic [4:0] exp_rd);
    @(posedge clk);
    while (!(result_valid && result_ready)) @(posedge clk);
    check_word({name, "_data"}, exp_data, result_data);
    check_id({name, "_id"}, exp_id, result_id);
    check_word({name, "_rd"}, DATA_W'(exp_rd), DATA_W'(result_rd));
  endtask

  task automatic run_entry(input int k);
    logic [DATA_W-1:0] a, b;
    logic              acc, wb;
    a = $urandom;
    b = $urandom;
    @(negedge clk);
    result_ready = (thold[k] == 0);
    do_issue(tinstr[k], a, b, ID_W'(k), acc, wb);
    check_bit({tname[k], "_accept"}, texp_acc[k], acc);
    check_bit({tname[k], "_writeback"}, texp_acc[k], wb);
    if (texp_res[k]) begin
      // result sits in the output register while ready is held off.
      repeat (thold[k]) @(negedge clk);
      // loaded on the handshake edge and still held.
      check_bit({tname[k], "_result_valid"}, 1'b1, result_valid);
      result_ready = 1'b1;
      get_result(tname[k], expect_alu(tinstr[k].f.funct3, a, b), ID_W'(k), tinstr[k].f.rd);
    end else begin
      result_ready = 1'b1;
      repeat (5) begin
        @(posedge clk);
        check_bit({tname[k], "_no_result"}, 1'b0, result_valid);
      end
    end
  endtask

  initial begin
    logic [DATA_W-1:0] rd_data, a, b, a2, b2, exp_a, exp_b;
    logic              err, acc, wb;
    void'($urandom(SEED));
    arst_n       = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_rs1    = '0;
    issue_rs2    = '0;
    issue_id     = '0;
    result_ready = 1'b1;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_bit("reset_issue_ready", 1'b1, issue_ready);
    check_bit("reset_result_valid", 1'b0, result_valid);
    check_bit("reset_pslverr", 1'b0, pslverr);

    // rule programming with junk upper bits that must read back as zero.
    for (int i = 0; i < 6; i++) begin
      apb_write(i, {24'($urandom), RULE_VAL[i]}, err);
      check_bit($sformatf("rule_write%0d_slverr", i), 1'b0, err);
    end
    for (int i = 0; i < 6; i++) begin
      apb_read(i, rd_data, err);
      check_bit($sformatf("rule_read%0d_slverr", i), 1'b0, err);
      check_word($sformatf("rule_read%0d", i), DATA_W'(RULE_VAL[i]), rd_data);
    end
    apb_write(6, 32'h0000_008B, err);
    check_bit("bad_write_slverr", 1'b1, err);
    apb_read(6, rd_data, err);
    check_bit("bad_read_slverr", 1'b1, err);
    check_word("bad_read_data", '0, rd_data);

    // routing, compute and default fallback.
    for (int k = 0; k < N_ROUTE; k++) run_entry(k);

    // priority check with 0x5B enabled on both coprocessor 0 and 1.
    apb_write(1, 32'h0000_00DB, err);
    apb_write(3, 32'h0000_00DB, err);
    run_entry(11);
    apb_write(1, 32'h0000_005B, err);
    run_entry(12);

    // the second back-pressure issue stalls behind the held result.
    @(negedge clk);
    result_ready = 1'b0;
    a     = $urandom;
    b     = $urandom;
    a2    = $urandom;
    b2    = $urandom;
    exp_a = expect_alu(3'd0, a, b);
    exp_b = expect_alu(3'd1, a2, b2);
    do_issue(make_instr(7'h0B, 3'd0, 5'd9), a, b, ID_W'(13), acc, wb);
    check_bit("bp_first_accept", 1'b1, acc);
    check_bit("bp_first_writeback", 1'b1, wb);
    @(negedge clk);
    issue_valid = 1'b1;
    issue_instr = make_instr(7'h0B, 3'd1, 5'd10);
    issue_rs1   = a2;
    issue_rs2   = b2;
    issue_id    = ID_W'(14);
    repeat (4) begin
      @(posedge clk);
      check_bit("bp_stall_ready", 1'b0, issue_ready);
      check_bit("bp_held_valid", 1'b1, result_valid);
      check_word("bp_held_data", exp_a, result_data);
    end
    // on release the first result drains on the edge that takes the second issue.
    @(negedge clk);
    result_ready = 1'b1;
    get_result("bp_first", exp_a, ID_W'(13), 5'd9);
    check_bit("bp_second_ready", 1'b1, issue_ready);
    check_bit("bp_second_accept", 1'b1, issue_accept);
    check_bit("bp_second_writeback", 1'b1, issue_writeback);
    @(negedge clk);
    issue_valid = 1'b0;
    get_result("bp_second", exp_b, ID_W'(14), 5'd10);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : xif_subsys_tb

//--- build.f
+incdir+design
design/xif_pkg.sv
design/xif_rule_regs.sv
design/xif_issue_demux.sv
design/xif_coproc.sv
design/xif_result_arb.sv
design/xif_subsys_top.sv
sim/xif_subsys_tb.sv

//--- Makefile
# Verilator flow for the coprocessor subsystem, run from the project root.
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= xif_subsys_tb
RTL_TOP   ?= xif_subsys_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

# lint the whole tree through the testbench top.
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# build, run, and fail unless the pass line shows up in the output.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
